// File: pool_arbiter_top.f
+incdir+source
source/token_types_pkg.sv
source/arb_types_pkg.sv
source/token_manager.sv
source/arb_rr_mul.sv
source/pool_arbiter_top.sv
tb/tb_pool_arbiter_top.sv

// File: Makefile
# Verilator build and run for the pool allocator

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only -Wall --timing
TOP       = tb_pool_arbiter_top
FILELIST  = pool_arbiter_top.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Result comes from the log, not from the exit status of the model
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/pool_arbiter_patterns.txt
# columns: req  gnt  gnt_id  (hex; gnt and gnt_id are expected one edge after req is sampled)
# gnt_id packs one token id per port, port 0 in the low bits; only granted ports are checked
# reset idle, lone request from port 2, then port 3 to park the pointer at port 3
0 0 0
4 4 0
0 0 0
8 8 0
0 0 0
# all ports request, port 0 then port 1, then back-pressure
f 1 0
f 3 2
f 3 2
f 3 2
f 3 2
# ports 0 and 1 release, ports 2 and 3 go first
c 0 0
f 4 0
f c 8
f c 8
# port 2 releases, its token goes to port 0 one edge later
b 8 8
b 9 8
b 9 8
# ports 0 and 3 release together, ports 1 and 2 get ids 0 and 1
6 0 0
6 2 0
6 6 4
6 6 4
0 0 0
0 0 0
# lowest free token is 1 when token 0 is still held
3 1 0
3 3 2
b 3 2
a 2 2
a a 2
8 8 0
9 9 1
9 9 1
0 0 0
0 0 0

// File: tb/tb_pool_arbiter_top.sv
`timescale 1ns/1ps

`include "pool_params.svh"

module tb_pool_arbiter_top;

    import arb_types_pkg::*;
    import token_types_pkg::*;

    // ------------------------------------------------------------
    // Bench constants
    // ------------------------------------------------------------

    localparam int    MAX_PATTERNS = 256;
    localparam int    RESET_CYCLES = 8;
    localparam int    REPLAY_SLACK = 16;
    localparam int    IDS_W        = `POOL_PORTS_N * TOKEN_ID_W;
    localparam string PATTERN_FILE = "tb/pool_arbiter_patterns.txt";

    logic        clk;
    logic        reset;
    port_vec_t   req;
    port_grant_t grant;

    // Pattern storage, one entry per cycle
    port_vec_t          pat_req [MAX_PATTERNS];
    port_vec_t          pat_gnt [MAX_PATTERNS];
    logic [IDS_W-1:0]   pat_ids [MAX_PATTERNS];
    int                 n_pat;

    int  err_cnt;
    int  check_cnt;
    bit  load_ok;

    pool_arbiter_top pool_arbiter_top_i (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .grant (grant)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Pattern file reader
    // ------------------------------------------------------------

    task automatic load_patterns(output bit ok);
        int               fd;
        int               rc;
        int               line_no;
        string            line;
        port_vec_t        r;
        port_vec_t        g;
        logic [IDS_W-1:0] ids;
        ok      = 1'b1;
        n_pat   = 0;
        line_no = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("ERROR cannot open pattern file %s", PATTERN_FILE);
            err_cnt++;
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                line_no++;
                // Skip comment and blank lines
                if (rc > 0 && line.len() > 0 && line.getc(0) != "#") begin
                    rc = $sscanf(line, "%h %h %h", r, g, ids);
                    if (rc == 1 || rc == 2) begin
                        $display("ERROR pattern line %0d has fewer than three fields", line_no);
                        err_cnt++;
                        ok = 1'b0;
                    end else if (rc == 3 && n_pat >= MAX_PATTERNS) begin
                        $display("ERROR pattern file holds more than %0d lines", MAX_PATTERNS);
                        err_cnt++;
                        ok = 1'b0;
                    end else if (rc == 3) begin
                        pat_req[n_pat] = r;
                        pat_gnt[n_pat] = g;
                        pat_ids[n_pat] = ids;
                        n_pat++;
                    end
                end
            end
            $fclose(fd);
            if (ok && n_pat == 0) begin
                $display("ERROR pattern file holds no data lines");
                err_cnt++;
                ok = 1'b0;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    // Grant vector, ids of granted ports, holder count
    task automatic check_line(int n);
        port_idx_t pi;
        token_id_t exp_id;
        check_cnt++;
        assert (grant.gnt === pat_gnt[n]) else begin
            err_cnt++;
            $display("FAILED grant.gnt line %0d: expected 0x%h actual 0x%h",
                     n, pat_gnt[n], grant.gnt);
        end
        for (int p = 0; p < `POOL_PORTS_N; p++) begin
            pi     = port_idx_t'(p);
            exp_id = pat_ids[n][p*TOKEN_ID_W +: TOKEN_ID_W];
            // Stale ids of idle ports carry no meaning
            if (pat_gnt[n][pi]) begin
                assert (grant.gnt_id[pi] === exp_id) else begin
                    err_cnt++;
                    $display("FAILED grant.gnt_id[%0d] line %0d: expected 0x%h actual 0x%h",
                             pi, n, exp_id, grant.gnt_id[pi]);
                end
            end
        end
        assert ($countones(grant.gnt) <= `POOL_GNTS_N) else begin
            err_cnt++;
            $display("FAILED grant.gnt line %0d: 0x%h holds more grants than tokens",
                     n, grant.gnt);
        end
    endtask

    // ------------------------------------------------------------
    // Reset and replay
    // ------------------------------------------------------------

    task automatic apply_reset();
        reset <= 1'b1;
        for (int c = 0; c < RESET_CYCLES - 1; c++) begin
            @(posedge clk);
        end
        // Grants must be idle while reset is held
        @(negedge clk);
        check_cnt++;
        assert (grant.gnt === '0) else begin
            err_cnt++;
            $display("FAILED grant.gnt in reset: expected 0x%h actual 0x%h",
                     port_vec_t'(0), grant.gnt);
        end
        @(posedge clk);
        reset <= 1'b0;
    endtask

    // Line n is driven at one edge, sampled at the next, checked after it
    task automatic replay_patterns();
        int idx;
        int cycles;
        idx    = 0;
        cycles = 0;
        while (idx <= n_pat) begin
            @(posedge clk);
            cycles++;
            if (cycles > n_pat + REPLAY_SLACK) begin
                $display("ERROR replay did not finish within %0d cycles", cycles);
                err_cnt++;
                break;
            end
            if (idx < n_pat) begin
                req <= pat_req[idx];
            end
            @(negedge clk);
            if (idx > 0) begin
                check_line(idx - 1);
            end
            idx++;
        end
    endtask

    initial begin
        reset     = 1'b1;
        req       = '0;
        err_cnt   = 0;
        check_cnt = 0;
        load_patterns(load_ok);
        if (load_ok) begin
            apply_reset();
            replay_patterns();
        end
        $display("patterns %0d, checks %0d, errors %0d", n_pat, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: source/pool_arbiter_top.sv
`timescale 1ns/1ps

module pool_arbiter_top (
    input  logic                       clk,
    input  logic                       reset,
    input  arb_types_pkg::port_vec_t   req,
    output arb_types_pkg::port_grant_t grant
);

    import token_types_pkg::*;

    // ------------------------------------------------------------
    // Links between arbiter and token manager
    // ------------------------------------------------------------

    // Lowest free token, combinational from the bitmap
    token_offer_t offer;

    // Offered token used this cycle
    logic         take;

    // Tokens released this cycle
    token_vec_t   give_back;

    // Free list of resource tokens
    token_manager token_manager_i (
        .clk       (clk),
        .reset     (reset),
        .take      (take),
        .give_back (give_back),
        .offer     (offer)
    );

    // Grant state and round-robin choice
    arb_rr_mul arb_rr_mul_i (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .offer     (offer),
        .take      (take),
        .give_back (give_back),
        .grant     (grant)
    );

endmodule

// File: source/arb_rr_mul.sv
`timescale 1ns/1ps

`include "pool_params.svh"

module arb_rr_mul (
    input  logic                          clk,
    input  logic                          reset,
    input  arb_types_pkg::port_vec_t      req,
    input  token_types_pkg::token_offer_t offer,
    output logic                          take,
    output token_types_pkg::token_vec_t   give_back,
    output arb_types_pkg::port_grant_t    grant
);

    import arb_types_pkg::*;
    import token_types_pkg::*;

    // ------------------------------------------------------------
    // State
    // ------------------------------------------------------------

    // Grant level per port
    port_vec_t gnt_q;

    // Token held by each port, stale while its grant is low
    token_id_t [`POOL_PORTS_N-1:0] gnt_id_q;

    // Last granted port
    port_idx_t rr_ptr;

    // ------------------------------------------------------------
    // Pending and dropped ports
    // ------------------------------------------------------------

    port_vec_t pending;
    port_vec_t drop_vec;
    port_vec_t pick_onehot;
    port_idx_t pick_idx;
    logic      pick_found;

    // Asking but not yet holding
    assign pending  = req & ~gnt_q;

    // Holding but no longer asking
    assign drop_vec = gnt_q & ~req;

    // ------------------------------------------------------------
    // Round-robin pick
    // ------------------------------------------------------------

    // Search starts one past the pointer and wraps
    always_comb begin
        int cand;
        pick_found = 1'b0;
        pick_idx   = rr_ptr;
        cand       = 0;
        for (int k = 1; k <= `POOL_PORTS_N; k++) begin
            cand = (int'(rr_ptr) + k) % `POOL_PORTS_N;
            if (!pick_found && pending[cand]) begin
                pick_found = 1'b1;
                pick_idx   = port_idx_t'(cand);
            end
        end
    end

    // Grant only when the pool has a token
    assign take = pick_found && offer.avail;

    always_comb begin
        pick_onehot = '0;
        if (take) begin
            pick_onehot[pick_idx] = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Return mask
    // ------------------------------------------------------------

    // Several ports may drop on one edge
    always_comb begin
        give_back = '0;
        for (int p = 0; p < `POOL_PORTS_N; p++) begin
            if (drop_vec[p]) begin
                give_back[gnt_id_q[p]] = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    // Pointer at last port so port 0 goes first
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gnt_q  <= '0;
            rr_ptr <= port_idx_t'(`POOL_PORTS_N - 1);
        end else begin
            gnt_q <= (gnt_q & ~drop_vec) | pick_onehot;
            if (take) begin
                rr_ptr <= pick_idx;
            end
        end
    end

    // Record offered id for the winner
    always_ff @(posedge clk) begin
        if (take) begin
            gnt_id_q[pick_idx] <= offer.id;
        end
    end

    assign grant.gnt    = gnt_q;
    assign grant.gnt_id = gnt_id_q;

    // ------------------------------------------------------------
    // Pool consistency
    // ------------------------------------------------------------

    // Never more holders than tokens
    a_grant_count: assert property (
        @(posedge clk) disable iff (reset)
        $countones(gnt_q) <= `POOL_GNTS_N
    ) else $error("arb_rr_mul: more grants than tokens");

    // A token belongs to one holder at a time
    for (genvar a = 0; a < `POOL_PORTS_N; a++) begin : g_uniq_a
        for (genvar b = a + 1; b < `POOL_PORTS_N; b++) begin : g_uniq_b
            a_unique_id: assert property (
                @(posedge clk) disable iff (reset)
                !(gnt_q[a] && gnt_q[b] && (gnt_id_q[a] == gnt_id_q[b]))
            ) else $error("arb_rr_mul: ports %0d and %0d share a token", a, b);
        end
    end

endmodule

// File: source/token_manager.sv
`timescale 1ns/1ps

`include "pool_params.svh"

module token_manager (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          take,
    input  token_types_pkg::token_vec_t   give_back,
    output token_types_pkg::token_offer_t offer
);

    import token_types_pkg::*;

    // One bit per token, set while free
    token_vec_t free_map;

    // Decoded bit of the offered token
    token_vec_t take_mask;

    // ------------------------------------------------------------
    // Offer, straight from the free bitmap
    // ------------------------------------------------------------

    always_comb begin
        offer.avail = |free_map;
        offer.id    = '0;
        // Walk down so the lowest free bit wins
        for (int i = `POOL_GNTS_N - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                offer.id = token_id_t'(i);
            end
        end
    end

    // Only the offered token can be taken
    always_comb begin
        take_mask = '0;
        if (take) begin
            take_mask[offer.id] = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Bitmap update
    // ------------------------------------------------------------

    // All tokens free out of reset
    // Allocation and returns land on the same edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            free_map <= '1;
        end else begin
            free_map <= (free_map & ~take_mask) | give_back;
        end
    end

    // ------------------------------------------------------------
    // Checks on the arbiter side of the handshake
    // ------------------------------------------------------------

    // Arbiter must not take from an empty pool
    a_take_needs_avail: assert property (
        @(posedge clk) disable iff (reset)
        take |-> offer.avail
    ) else $error("token_manager: take without a free token");

    // Returned tokens must be allocated ones
    a_give_back_allocated: assert property (
        @(posedge clk) disable iff (reset)
        (give_back & free_map) == '0
    ) else $error("token_manager: give_back names a free token");

endmodule

// File: source/arb_types_pkg.sv
`include "pool_params.svh"

package arb_types_pkg;

    // Grant bundle carries token ids
    import token_types_pkg::*;

    // ------------------------------------------------------------
    // Requester side widths
    // ------------------------------------------------------------

    // Port index width, never below one bit
    localparam int PORT_IDX_W = (`POOL_PORTS_N > 1) ? $clog2(`POOL_PORTS_N) : 1;

    // One bit per requester, requests and grants
    typedef logic [`POOL_PORTS_N-1:0] port_vec_t;

    // Requester number, round-robin pointer
    typedef logic [PORT_IDX_W-1:0] port_idx_t;

    // ------------------------------------------------------------
    // Output bundle of arbiter and top level
    // ------------------------------------------------------------

    typedef struct packed {
        port_vec_t                        gnt;     // Grant level per port
        token_id_t [`POOL_PORTS_N-1:0]    gnt_id;  // Token held by each port
    } port_grant_t;

endpackage

// File: source/token_types_pkg.sv
`include "pool_params.svh"

package token_types_pkg;

    // ------------------------------------------------------------
    // Resource side widths
    // ------------------------------------------------------------

    // Token id width, never below one bit
    localparam int TOKEN_ID_W = (`POOL_GNTS_N > 1) ? $clog2(`POOL_GNTS_N) : 1;

    // Resource number
    typedef logic [TOKEN_ID_W-1:0] token_id_t;

    // One bit per resource, used for free set and returns
    typedef logic [`POOL_GNTS_N-1:0] token_vec_t;

    // ------------------------------------------------------------
    // Offer from token manager to arbiter
    // ------------------------------------------------------------

    typedef struct packed {
        logic      avail;   // Some token is free
        token_id_t id;      // Lowest free token
    } token_offer_t;

endpackage

// File: source/pool_params.svh
`ifndef POOL_PARAMS_SVH
`define POOL_PARAMS_SVH

// ------------------------------------------------------------
// Pool sizing
// ------------------------------------------------------------

// Number of requesters competing for the pool
`define POOL_PORTS_N 4

// Number of identical resources, one token each
// Keep at or below POOL_PORTS_N
`define POOL_GNTS_N 2

`endif
